// File: Makefile
TOP = videoTxTb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f compile.f --top-module $(TOP) -Mdir obj_dir

run: compile
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "All checks passed" sim.log

clean:
	rm -rf obj_dir sim.log

// File: compile.f
+incdir+design
design/videoTxPkg.sv
design/timingCfgIf.sv
design/videoTxCsr.sv
design/videoTimingGen.sv
design/backlightPwm.sv
design/videoTxTop.sv
testbench/videoTxTb.sv

// File: design/backlightPwm.sv
// free-running 8-bit PWM driving the panel backlight from a duty value
module backlightPwm (
	input  logic       iSysClk,
	input  logic       rst,
	input  logic [7:0] duty,
	output logic       bl
);

	logic [7:0] pwmCnt;  // 256-cycle period

	always_ff @(posedge iSysClk)
	begin
		if (rst)
			pwmCnt <= 8'h00;
		else
			pwmCnt <= pwmCnt + 8'h01;
	end

	// duty 0 stays off, 255 gives 255 of 256 on
	always_ff @(posedge iSysClk)
	begin
		if (rst)
			bl <= 1'b0;
		else
			bl <= (pwmCnt < duty);
	end

endmodule

// File: design/timingCfgIf.sv
// programmed and derived raster counts passed from the register block to the timing generator
interface timingCfgIf;
	import videoTxPkg::*;

	hCount_t hDisplay;
	vCount_t vDisplay;
	hSync_t  hSyncStart;  // display + front
	hSync_t  hSyncEnd;    // last cycle of the pulse
	hSync_t  hSyncMax;    // last cycle of the line
	vSync_t  vSyncStart;
	vSync_t  vSyncEnd;
	vSync_t  vSyncMax;

	modport csr (
		output hDisplay, vDisplay,
		output hSyncStart, hSyncEnd, hSyncMax,
		output vSyncStart, vSyncEnd, vSyncMax
	);

	modport gen (
		input hDisplay, vDisplay,
		input hSyncStart, hSyncEnd, hSyncMax,
		input vSyncStart, vSyncEnd, vSyncMax
	);

endinterface

// File: design/videoTimingGen.sv
// raster counters producing hsync, vsync, data enable and pixel coordinates
`include "videoTx_defs.svh"

module videoTimingGen (
	input  logic                iSysClk,
	input  logic                rst,
	input  logic                timingRst,
	timingCfgIf.gen             cfg,
	output logic                hsync,
	output logic                vsync,
	output logic                de,
	output logic [`H_WIDTH-1:0] pixX,
	output logic [`V_WIDTH-1:0] pixY
);
	import videoTxPkg::*;

	hSync_t hCnt;
	vSync_t vCnt;
	hPhase_e hPhase;
	logic lineEnd;
	logic frameEnd;
	logic cntClr;

	assign cntClr   = rst | timingRst;
	// >= so a shrunk config wraps at once
	assign lineEnd  = (hCnt >= cfg.hSyncMax);
	assign frameEnd = (vCnt >= cfg.vSyncMax);

	// ------------------------------
	// counters
	// ------------------------------
	always_ff @(posedge iSysClk)
	begin
		if (cntClr)
		begin
			hCnt <= '0;
			vCnt <= '0;
		end
		else if (lineEnd)
		begin
			hCnt <= '0;
			vCnt <= frameEnd ? '0 : vCnt + vSync_t'(1);  // one line down
		end
		else
			hCnt <= hCnt + hSync_t'(1);
	end

	// classify the horizontal position
	always_comb
	begin
		if (hCnt < hSync_t'(cfg.hDisplay))
			hPhase = H_ACTIVE;
		else if (hCnt < cfg.hSyncStart)
			hPhase = H_FRONT;
		else if (hCnt <= cfg.hSyncEnd)
			hPhase = H_SYNC;
		else
			hPhase = H_BACK;
	end

	// ------------------------------
	// registered panel outputs
	// ------------------------------
	always_ff @(posedge iSysClk)
	begin
		if (cntClr)
		begin
			hsync <= 1'b0;
			vsync <= 1'b0;
			de    <= 1'b0;
			pixX  <= '0;
			pixY  <= '0;
		end
		else
		begin
			hsync <= (hPhase == H_SYNC);
			vsync <= (vCnt >= cfg.vSyncStart) && (vCnt <= cfg.vSyncEnd);
			de    <= (hPhase == H_ACTIVE) && (vCnt < vSync_t'(cfg.vDisplay));
			pixX  <= hCnt[`H_WIDTH-1:0];
			pixY  <= vCnt[`V_WIDTH-1:0];
		end
	end

	// sync pulse and active video never overlap on the panel
	noSyncInActive: assert property (@(posedge iSysClk) disable iff (rst)
		!(hsync && de));

endmodule

// File: design/videoTxCsr.sv
// Wishbone classic register block holding panel timing, control bits and backlight duty
`include "videoTx_defs.svh"

module videoTxCsr (
	input  logic                      iSysClk,
	input  logic                      rst,
	input  logic                      wbCyc,
	input  logic                      wbStb,
	input  logic                      wbWe,
	input  logic [`CSR_ADR_WIDTH-1:0] wbAdr,
	input  logic [31:0]               wbDatW,
	output logic [31:0]               wbDatR,
	output logic                      wbAck,
	timingCfgIf.csr                   cfg,
	output logic                      timingRst,
	output logic                      displayRst,
	output logic                      dmaEn,
	output logic [7:0]                blDuty
);
	import videoTxPkg::*;

	logic req;       // new access, not yet acked
	logic blockHit;
	logic wrEn;
	csrReg_e regOfs;
	logic [31:0] rdData;

	hCount_t hDisplay;
	vCount_t vDisplay;
	logic [`PORCH_WIDTH-1:0] hFront, hBack, hPulse;
	logic [`PORCH_WIDTH-1:0] vFront, vBack, vPulse;

	assign req      = wbCyc & wbStb & ~wbAck;
	assign blockHit = (wbAdr[15:8] == `CSR_BLOCK_BASE);
	assign wrEn     = req & wbWe & blockHit;
	assign regOfs   = csrReg_e'(wbAdr[`CSR_OFS_WIDTH-1:0]);

	// ------------------------------
	// field registers
	// ------------------------------
	always_ff @(posedge iSysClk)
	begin
		if (rst)
		begin
			hDisplay   <= `H_DISPLAY_RST;
			hFront     <= `H_FRONT_RST;
			hBack      <= `H_BACK_RST;
			hPulse     <= `H_PULSE_RST;
			vDisplay   <= `V_DISPLAY_RST;
			vFront     <= `V_FRONT_RST;
			vBack      <= `V_BACK_RST;
			vPulse     <= `V_PULSE_RST;
			timingRst  <= 1'b1;  // raster held until software releases it
			displayRst <= 1'b1;
			dmaEn      <= 1'b0;
			blDuty     <= 8'h00; // backlight off
		end
		else if (wrEn)
		begin
			case (regOfs)
				REG_DISPLAY:
				begin
					hDisplay <= wbDatW[`H_WIDTH-1:0];
					vDisplay <= wbDatW[16 +: `V_WIDTH];
				end
				REG_BACK:
				begin
					hBack <= wbDatW[`PORCH_WIDTH-1:0];
					vBack <= wbDatW[16 +: `PORCH_WIDTH];
				end
				REG_FRONT:
				begin
					hFront <= wbDatW[`PORCH_WIDTH-1:0];
					vFront <= wbDatW[16 +: `PORCH_WIDTH];
				end
				REG_PULSE:
				begin
					hPulse <= wbDatW[`PORCH_WIDTH-1:0];
					vPulse <= wbDatW[16 +: `PORCH_WIDTH];
				end
				REG_CTRL:
				begin
					timingRst  <= wbDatW[0];
					displayRst <= wbDatW[1];
					dmaEn      <= wbDatW[2];
				end
				REG_DUTY: blDuty <= wbDatW[7:0];
				default: ;  // sync registers are read only
			endcase
		end
	end

	// derived counts, recomputed every cycle from the fields
	always_ff @(posedge iSysClk)
	begin
		cfg.hSyncStart <= hSync_t'(hDisplay) + hSync_t'(hFront);
		cfg.hSyncEnd   <= hSync_t'(hDisplay) + hSync_t'(hFront) + hSync_t'(hPulse) - hSync_t'(1);
		cfg.hSyncMax   <= hSync_t'(hDisplay) + hSync_t'(hFront) + hSync_t'(hPulse)
			+ hSync_t'(hBack) - hSync_t'(1);
		cfg.vSyncStart <= vSync_t'(vDisplay) + vSync_t'(vFront);
		cfg.vSyncEnd   <= vSync_t'(vDisplay) + vSync_t'(vFront) + vSync_t'(vPulse) - vSync_t'(1);
		cfg.vSyncMax   <= vSync_t'(vDisplay) + vSync_t'(vFront) + vSync_t'(vPulse)
			+ vSync_t'(vBack) - vSync_t'(1);
	end

	assign cfg.hDisplay = hDisplay;
	assign cfg.vDisplay = vDisplay;

	// ------------------------------
	// read back and ack
	// ------------------------------
	always_comb
	begin
		rdData = '0;  // unmapped and foreign reads return zero
		if (blockHit)
		begin
			case (regOfs)
				REG_DISPLAY: rdData = {{(16-`V_WIDTH){1'b0}}, vDisplay,
					{(16-`H_WIDTH){1'b0}}, hDisplay};
				REG_BACK:    rdData = {{(16-`PORCH_WIDTH){1'b0}}, vBack,
					{(16-`PORCH_WIDTH){1'b0}}, hBack};
				REG_FRONT:   rdData = {{(16-`PORCH_WIDTH){1'b0}}, vFront,
					{(16-`PORCH_WIDTH){1'b0}}, hFront};
				REG_PULSE:   rdData = {{(16-`PORCH_WIDTH){1'b0}}, vPulse,
					{(16-`PORCH_WIDTH){1'b0}}, hPulse};
				REG_CTRL:    rdData = {29'd0, dmaEn, displayRst, timingRst};
				REG_DUTY:    rdData = {24'd0, blDuty};
				REG_SYNC_START: rdData = {{(15-`V_WIDTH){1'b0}}, cfg.vSyncStart,
					{(15-`H_WIDTH){1'b0}}, cfg.hSyncStart};
				REG_SYNC_END:   rdData = {{(15-`V_WIDTH){1'b0}}, cfg.vSyncEnd,
					{(15-`H_WIDTH){1'b0}}, cfg.hSyncEnd};
				REG_SYNC_MAX:   rdData = {{(15-`V_WIDTH){1'b0}}, cfg.vSyncMax,
					{(15-`H_WIDTH){1'b0}}, cfg.hSyncMax};
				default: rdData = '0;
			endcase
		end
	end

	always_ff @(posedge iSysClk)
	begin
		if (rst)
			wbAck <= 1'b0;
		else
			wbAck <= req;  // every access acked, the bus never hangs
	end

	// data lands together with the ack
	always_ff @(posedge iSysClk)
	begin
		if (req)
			wbDatR <= rdData;
	end

	// a held strobe must not see a second ack
	ackSinglePulse: assert property (@(posedge iSysClk) disable iff (rst)
		wbAck |=> !wbAck);

endmodule

// File: design/videoTxPkg.sv
// register offsets, raster phases and count types shared across the video transmit blocks
`include "videoTx_defs.svh"

package videoTxPkg;

	typedef logic [`H_WIDTH-1:0] hCount_t;  // display-sized counts
	typedef logic [`V_WIDTH-1:0] vCount_t;
	typedef logic [`H_WIDTH:0]   hSync_t;   // derived counts, one spare bit for the blanking
	typedef logic [`V_WIDTH:0]   vSync_t;

	// word offsets inside the block
	typedef enum logic [`CSR_OFS_WIDTH-1:0] {
		REG_DISPLAY    = 8'h00,
		REG_BACK       = 8'h04,
		REG_FRONT      = 8'h08,
		REG_PULSE      = 8'h0C,
		REG_CTRL       = 8'h10,
		REG_DUTY       = 8'h14,
		REG_SYNC_START = 8'h80,  // read only from here on
		REG_SYNC_END   = 8'h84,
		REG_SYNC_MAX   = 8'h88
	} csrReg_e;

	// where the horizontal counter sits within a line
	typedef enum logic [1:0] {
		H_ACTIVE,
		H_FRONT,
		H_SYNC,
		H_BACK
	} hPhase_e;

endpackage

// File: design/videoTxTop.sv
// video transmit controller top with Wishbone register port and parallel RGB panel timing
`include "videoTx_defs.svh"

module videoTxTop (
	input  logic                      iSysClk,
	input  logic                      rst,
	input  logic                      wbCyc,
	input  logic                      wbStb,
	input  logic                      wbWe,
	input  logic [`CSR_ADR_WIDTH-1:0] wbAdr,
	input  logic [31:0]               wbDatW,
	output logic [31:0]               wbDatR,
	output logic                      wbAck,
	output logic                      hsync,
	output logic                      vsync,
	output logic                      de,
	output logic [`H_WIDTH-1:0]       pixX,
	output logic [`V_WIDTH-1:0]       pixY,
	output logic                      bl,
	output logic                      displayRst,
	output logic                      dmaEn
);

	logic timingRst;
	logic [7:0] blDuty;

	timingCfgIf cfgIf ();  // programmed and derived raster counts

	// ------------------------------
	// register block
	// ------------------------------
	videoTxCsr videoTxCsr_inst (
		.iSysClk    (iSysClk),
		.rst        (rst),
		.wbCyc      (wbCyc),
		.wbStb      (wbStb),
		.wbWe       (wbWe),
		.wbAdr      (wbAdr),
		.wbDatW     (wbDatW),
		.wbDatR     (wbDatR),
		.wbAck      (wbAck),
		.cfg        (cfgIf.csr),
		.timingRst  (timingRst),
		.displayRst (displayRst),
		.dmaEn      (dmaEn),
		.blDuty     (blDuty)
	);

	// ------------------------------
	// panel side
	// ------------------------------
	videoTimingGen videoTimingGen_inst (
		.iSysClk   (iSysClk),
		.rst       (rst),
		.timingRst (timingRst),
		.cfg       (cfgIf.gen),
		.hsync     (hsync),
		.vsync     (vsync),
		.de        (de),
		.pixX      (pixX),
		.pixY      (pixY)
	);

	backlightPwm backlightPwm_inst (
		.iSysClk (iSysClk),
		.rst     (rst),
		.duty    (blDuty),
		.bl      (bl)
	);

endmodule

// File: design/videoTx_defs.svh
// widths, reset timing and address map constants of the video transmit controller
`ifndef VIDEOTX_DEFS_SVH
`define VIDEOTX_DEFS_SVH

// ------------------------------
// field widths
// ------------------------------
`define H_WIDTH        11   // horizontal counts
`define V_WIDTH        11   // vertical counts
`define PORCH_WIDTH    7    // every porch and pulse field

// ------------------------------
// reset timing, 480x272 panel
// ------------------------------
`define H_DISPLAY_RST  11'd480
`define H_FRONT_RST    7'd8
`define H_BACK_RST     7'd43
`define H_PULSE_RST    7'd30

`define V_DISPLAY_RST  11'd272
`define V_FRONT_RST    7'd12
`define V_BACK_RST     7'd4
`define V_PULSE_RST    7'd10

// ------------------------------
// address map
// ------------------------------
`define CSR_ADR_WIDTH  16     // wbAdr width
`define CSR_BLOCK_BASE 8'h04  // block select in wbAdr[15:8]
`define CSR_OFS_WIDTH  8      // register offset in wbAdr[7:0]

`endif

// File: testbench/videoTxTb.sv
// testbench for the video transmit controller covering registers, raster timing and backlight
`include "videoTx_defs.svh"

module videoTxTb;
	import videoTxPkg::*;

	localparam int cycleLimit = 20000;  // all tests with small frames plus margin

	logic iSysClk, rst, wbCyc, wbStb, wbWe, wbAck;
	logic [`CSR_ADR_WIDTH-1:0] wbAdr;
	logic [31:0] wbDatW, wbDatR;
	logic hsync, vsync, de, bl, displayRst, dmaEn;
	logic [`H_WIDTH-1:0] pixX;
	logic [`V_WIDTH-1:0] pixY;
	int cycleCnt;

	// register model
	logic [31:0] hDispM, hFrontM, hBackM, hPulseM, vDispM, vFrontM, vBackM, vPulseM;
	logic [31:0] ctrlM, dutyM;
	logic [7:0] offsetList [0:11] = '{8'h00, 8'h04, 8'h08, 8'h0C, 8'h10, 8'h14,
		8'h80, 8'h84, 8'h88, 8'h18, 8'h40, 8'h8C};

	videoTxTop videoTxTop_inst (.*);

	initial
	begin
		iSysClk = 1'b0;
		forever #4 iSysClk = ~iSysClk;
	end

	// ------------------------------
	// failure handling and bus tasks
	// ------------------------------
	task automatic failStop();
		$display("Checks failed");
		$fatal(1, "stopped at the first error");
	endtask

	task automatic expectEqual(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		assert (got == exp)
		else
		begin
			$display("Mismatch %s: got 0x%h expected 0x%h", name, got, exp);
			failStop();
		end
	endtask

	task automatic tick();
		@(posedge iSysClk);
		#1;  // drive and sample just after the edge
	endtask

	function automatic logic [15:0] regAdr(input csrReg_e r);
		return {`CSR_BLOCK_BASE, 8'(r)};
	endfunction

	function automatic logic [31:0] packPair(input logic [31:0] v, input logic [31:0] h);
		return ((v & 32'hFFF) << 16) | (h & 32'hFFF);  // 12-bit halves of the sync regs
	endfunction

	function automatic logic [31:0] hTotal();
		return hDispM + hFrontM + hPulseM + hBackM;
	endfunction

	function automatic logic [31:0] vTotal();
		return vDispM + vFrontM + vPulseM + vBackM;
	endfunction

	function automatic void mirrorWrite(input logic [15:0] adr, input logic [31:0] data);
		if (adr[15:8] == `CSR_BLOCK_BASE)
		begin
			case (csrReg_e'(adr[7:0]))
				REG_DISPLAY:
				begin
					hDispM = data & 32'h7FF;
					vDispM = (data >> 16) & 32'h7FF;
				end
				REG_BACK:
				begin
					hBackM = data & 32'h7F;
					vBackM = (data >> 16) & 32'h7F;
				end
				REG_FRONT:
				begin
					hFrontM = data & 32'h7F;
					vFrontM = (data >> 16) & 32'h7F;
				end
				REG_PULSE:
				begin
					hPulseM = data & 32'h7F;
					vPulseM = (data >> 16) & 32'h7F;
				end
				REG_CTRL: ctrlM = data & 32'h7;
				REG_DUTY: dutyM = data & 32'hFF;
				default: ;  // read only or unmapped
			endcase
		end
	endfunction

	function automatic logic [31:0] predictRead(input logic [15:0] adr);
		logic [31:0] res;
		res = '0;
		if (adr[15:8] == `CSR_BLOCK_BASE)
		begin
			case (csrReg_e'(adr[7:0]))
				REG_DISPLAY:    res = packPair(vDispM, hDispM);
				REG_BACK:       res = packPair(vBackM, hBackM);
				REG_FRONT:      res = packPair(vFrontM, hFrontM);
				REG_PULSE:      res = packPair(vPulseM, hPulseM);
				REG_CTRL:       res = ctrlM;
				REG_DUTY:       res = dutyM;
				REG_SYNC_START: res = packPair(vDispM + vFrontM, hDispM + hFrontM);
				REG_SYNC_END:   res = packPair(vDispM + vFrontM + vPulseM - 1,
					hDispM + hFrontM + hPulseM - 1);
				REG_SYNC_MAX:   res = packPair(vTotal() - 1, hTotal() - 1);
				default:        res = '0;
			endcase
		end
		return res;
	endfunction

	// one access with the master holding until ack
	task automatic busAccess(input logic we, input logic [15:0] adr, input logic [31:0] data,
		output logic [31:0] rdData);
		int waitCnt;
		waitCnt = 0;
		wbCyc = 1'b1;
		wbStb = 1'b1;
		wbWe = we;
		wbAdr = adr;
		wbDatW = data;
		do
		begin
			tick();
			waitCnt++;
			assert (waitCnt <= 4)
			else
			begin
				$display("Wishbone ack did not arrive within 4 cycles at address 0x%h", adr);
				failStop();
			end
		end while (!wbAck);
		rdData = wbDatR;
		wbCyc = 1'b0;
		wbStb = 1'b0;
		wbWe = 1'b0;
		if (we)
			mirrorWrite(adr, data);
		tick();  // idle cycle between accesses
	endtask

	task automatic writeReg(input logic [15:0] adr, input logic [31:0] data);
		logic [31:0] unused;
		busAccess(1'b1, adr, data, unused);
	endtask

	task automatic readCheck(input logic [15:0] adr);
		logic [31:0] got;
		busAccess(1'b0, adr, 32'h0, got);
		expectEqual($sformatf("wbDatR@%h", adr), got, predictRead(adr));
	endtask

	task automatic programTiming(input int maxDisp, input int maxPorch);
		writeReg(regAdr(REG_DISPLAY),
			($urandom_range(maxDisp, 8) << 16) | $urandom_range(maxDisp, 8));
		writeReg(regAdr(REG_FRONT),
			($urandom_range(maxPorch, 1) << 16) | $urandom_range(maxPorch, 1));
		writeReg(regAdr(REG_PULSE),
			($urandom_range(maxPorch, 1) << 16) | $urandom_range(maxPorch, 1));
		writeReg(regAdr(REG_BACK),
			($urandom_range(maxPorch, 1) << 16) | $urandom_range(maxPorch, 1));
	endtask

	// ------------------------------
	// raster measurement
	// ------------------------------
	task automatic checkRaster();
		int cyc, lastHRise, lastVRise, hRises, vRises, pulseCnt, lineDe, frameLines;
		logic prevH, prevV;
		cyc = 0;
		lastHRise = 0;
		lastVRise = 0;
		hRises = 0;
		vRises = 0;
		pulseCnt = 0;
		lineDe = 0;
		frameLines = 0;
		prevH = 1'b0;
		prevV = 1'b0;
		while (vRises < 3)  // two full frames between three vsync edges
		begin
			tick();
			cyc++;
			if (de)
			begin
				lineDe++;
				if (hRises > 0)
					expectEqual("pixX", 32'(pixX), lineDe - 1);  // column within the line
				if (vRises > 0)
					expectEqual("pixY", 32'(pixY), frameLines);
			end
			if (hsync)
				pulseCnt++;
			if (prevH && !hsync)
			begin
				expectEqual("hsync pulse width", pulseCnt, hPulseM);
				pulseCnt = 0;
			end
			if (hsync && !prevH)
			begin
				if (hRises > 0)
					expectEqual("hsync period", cyc - lastHRise, hTotal());
				if (hRises > 0 && lineDe != 0)
				begin
					expectEqual("de per line", lineDe, hDispM);
					frameLines++;
				end
				lineDe = 0;
				lastHRise = cyc;
				hRises++;
			end
			if (vsync && !prevV)
			begin
				if (vRises > 0)
				begin
					expectEqual("vsync period", cyc - lastVRise, vTotal() * hTotal());
					expectEqual("de lines per frame", frameLines, vDispM);
				end
				frameLines = 0;
				lastVRise = cyc;
				vRises++;
			end
			prevH = hsync;
			prevV = vsync;
		end
	endtask

	// cycle limit watchdog
	initial
	begin
		cycleCnt = 0;
		forever
		begin
			@(posedge iSysClk);
			cycleCnt++;
			assert (cycleCnt < cycleLimit)
			else
			begin
				$display("Timeout: the run did not finish within %0d cycles", cycleLimit);
				failStop();
			end
		end
	end

	// ------------------------------
	// test sequence
	// ------------------------------
	initial
	begin
		logic [15:0] adr;
		logic [7:0] blk;
		logic [31:0] val;
		int idx, highCnt;
		void'($urandom(89));
		rst = 1'b1;
		wbCyc = 1'b0;
		wbStb = 1'b0;
		wbWe = 1'b0;
		wbAdr = '0;
		wbDatW = '0;
		hDispM = 32'(`H_DISPLAY_RST);
		hFrontM = 32'(`H_FRONT_RST);
		hBackM = 32'(`H_BACK_RST);
		hPulseM = 32'(`H_PULSE_RST);
		vDispM = 32'(`V_DISPLAY_RST);
		vFrontM = 32'(`V_FRONT_RST);
		vBackM = 32'(`V_BACK_RST);
		vPulseM = 32'(`V_PULSE_RST);
		ctrlM = 32'h3;  // timingRst and displayRst set
		dutyM = 32'h0;
		repeat (2) @(posedge iSysClk);
		#1;
		rst = 1'b0;
		tick();

		// reset values
		expectEqual("displayRst", 32'(displayRst), 32'h1);
		expectEqual("dmaEn", 32'(dmaEn), 32'h0);
		expectEqual("bl", 32'(bl), 32'h0);
		for (int i = 0; i < 9; i++)
			readCheck({`CSR_BLOCK_BASE, offsetList[i]});

		// random traffic including unmapped and foreign blocks
		for (int i = 0; i < 60; i++)
		begin
			idx = $urandom_range(11, 0);
			blk = ($urandom_range(5, 0) == 0) ? `CSR_BLOCK_BASE + 8'(1 + $urandom_range(3, 0))
				: `CSR_BLOCK_BASE;
			adr = ($urandom_range(7, 0) == 0) ? {blk, 8'($urandom)} : {blk, offsetList[idx]};
			if ($urandom_range(1, 0) == 1)
				writeReg(adr, $urandom);
			else
				readCheck(adr);
		end

		// derived sync counts
		for (int i = 0; i < 4; i++)
		begin
			programTiming(40, 8);
			readCheck(regAdr(REG_SYNC_START));
			readCheck(regAdr(REG_SYNC_END));
			readCheck(regAdr(REG_SYNC_MAX));
		end

		// raster with a small frame
		writeReg(regAdr(REG_CTRL), 32'h1);
		programTiming(24, 6);
		writeReg(regAdr(REG_CTRL), 32'h0);
		checkRaster();

		// backlight duty over one full PWM period
		for (int i = 0; i < 6; i++)
		begin
			val = (i == 0) ? 32'd0 : (i == 1) ? 32'd255 : $urandom_range(254, 1);
			writeReg(regAdr(REG_DUTY), val);
			tick();
			highCnt = 0;
			for (int c = 0; c < 256; c++)
			begin
				if (bl)
					highCnt++;
				tick();
			end
			expectEqual("bl high cycles", highCnt, val);
		end

		// control bits to the ports
		for (int i = 0; i < 8; i++)
		begin
			writeReg(regAdr(REG_CTRL), $urandom_range(7, 0));
			expectEqual("displayRst", 32'(displayRst), (ctrlM >> 1) & 32'h1);
			expectEqual("dmaEn", 32'(dmaEn), (ctrlM >> 2) & 32'h1);
			if (ctrlM[0])
				expectEqual("hsync/vsync/de", {29'd0, hsync, vsync, de}, 32'h0);
		end

		$display("All checks passed");
		$finish;
	end

endmodule
